//--- verilog/cachePkg.sv
package cachePkg;

  // address split, tag | index | offset
  localparam int TagBits    = 21;
  localparam int IndexBits  = 6;
  localparam int OffsetBits = 5;

  localparam int NumSets = 1 << IndexBits;
  localparam int NumWays = 2;

  // pipeline word and cache line widths
  localparam int WordBits = 64;
  localparam int LineBits = 256;

  typedef struct packed {
    logic [TagBits-1:0]    tag;
    logic [IndexBits-1:0]  index;
    logic [OffsetBits-1:0] offset;
  } addrFieldsT;

  // raw view goes to the bus, field view drives lookup
  typedef union packed {
    logic [31:0] raw;
    addrFieldsT  fields;
  } cacheAddrT;

  typedef struct packed {
    logic      valid;
    cacheAddrT addr;
  } cacheReqT;

  typedef struct packed {
    logic                dataOk;
    logic [WordBits-1:0] data;
  } cacheRespT;

endpackage

//--- verilog/busPkg.sv
package busPkg;

  // one line arrives as four beats
  localparam int BeatsPerLine = 4;
  localparam int BeatBits     = 64;

  // read beat from memory
  // valid strobes each beat, last marks the final one
  typedef struct packed {
    logic                valid;
    logic                last;
    logic [BeatBits-1:0] data;
  } busBeatT;

endpackage

//--- verilog/dataArray.sv
module dataArray (
  input  logic                                                 clk,
  input  logic                                                 rdEn_i,
  input  logic [cachePkg::IndexBits-1:0]                       rdIndex_i,
  output logic [cachePkg::NumWays-1:0][cachePkg::LineBits-1:0] rdLines_o,
  input  logic                                                 wrEn_i,
  input  logic                                                 wrWay_i,
  input  logic [cachePkg::IndexBits-1:0]                       wrIndex_i,
  input  logic [cachePkg::LineBits-1:0]                        wrLine_i
);
  import cachePkg::*;

  // one bank per way, both read in parallel
  for (genvar w = 0; w < NumWays; w++) begin : gWay
    logic [LineBits-1:0] lines [NumSets];
    logic [LineBits-1:0] rdLine;

    // whole-line write from the refill path
    always_ff @(posedge clk) begin
      if (wrEn_i && (wrWay_i == 1'(w))) begin
        lines[wrIndex_i] <= wrLine_i;
      end
    end

    // synchronous read, data one cycle after rdEn_i
    always_ff @(posedge clk) begin
      if (rdEn_i) begin
        rdLine <= lines[rdIndex_i];
      end
    end

    assign rdLines_o[w] = rdLine;
  end

endmodule

//--- verilog/refillBuffer.sv
module refillBuffer (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             clear_i,
  input  busPkg::busBeatT                                  mem_i,
  output logic                                             lineReady_o,
  output logic [busPkg::BeatsPerLine*busPkg::BeatBits-1:0] line_o
);
  import busPkg::*;

  logic [$clog2(BeatsPerLine)-1:0] beatCnt;
  logic                            lastBeat;

  assign lastBeat = mem_i.valid && mem_i.last;

  // beat counter picks the slot for the next beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt     <= '0;
      lineReady_o <= 1'b0;
    end else begin
      // line is complete once the last beat is stored
      lineReady_o <= lastBeat;
      if (clear_i) begin
        beatCnt <= '0;
      end else if (lastBeat) begin
        beatCnt <= '0;
      end else if (mem_i.valid) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // beat 0 lands in the low word
  always_ff @(posedge clk) begin
    if (mem_i.valid) begin
      line_o[beatCnt*BeatBits +: BeatBits] <= mem_i.data;
    end
  end

endmodule

//--- verilog/cacheCtrl.sv
module cacheCtrl (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  cachePkg::cacheReqT                                   req_i,
  output logic                                                 addrOk_o,
  output cachePkg::cacheRespT                                  resp_o,
  output logic                                                 memRdReq_o,
  output logic [31:0]                                          memAddr_o,
  output logic                                                 rdEn_o,
  output logic [cachePkg::IndexBits-1:0]                       rdIndex_o,
  input  logic [cachePkg::NumWays-1:0][cachePkg::LineBits-1:0] rdLines_i,
  output logic                                                 wrEn_o,
  output logic                                                 wrWay_o,
  output logic [cachePkg::IndexBits-1:0]                       wrIndex_o,
  output logic                                                 refillClear_o,
  input  logic                                                 lineReady_i,
  input  logic [cachePkg::LineBits-1:0]                        refillLine_i
);
  import cachePkg::*;

  typedef enum logic [1:0] {
    Idle,
    Compare,
    Miss,
    GetData
  } stateT;

  stateT                           state;
  stateT                           stateNext;
  cacheAddrT                       reqQ;
  cacheAddrT                       lineAddr;
  logic                            accept;
  logic                            compareHit;
  logic                            compareMiss;
  logic                            inGetData;
  logic [TagBits-1:0]              tagArr [NumWays][NumSets];
  logic [NumWays-1:0][NumSets-1:0] validArr;
  logic [NumSets-1:0]              lruArr;
  logic [NumWays-1:0][TagBits-1:0] tagQ;
  logic [NumWays-1:0]              validQ;
  logic [NumWays-1:0]              wayHit;
  logic                            hit;
  logic                            hitWay;
  logic                            victim;
  logic                            victimQ;
  logic                            dataOkQ;
  logic [WordBits-1:0]             dataQ;

  // offset bits 4:3 pick one of four words
  function automatic logic [WordBits-1:0] selectWord(
    input logic [LineBits-1:0]   line,
    input logic [OffsetBits-1:0] offset
  );
    logic [1:0] wordSel;
    wordSel = offset[4:3];
    return line[wordSel*WordBits +: WordBits];
  endfunction

  // tag compare against both ways
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = validQ[w] && (tagQ[w] == reqQ.fields.tag);
    end
  end

  assign hit    = |wayHit;
  assign hitWay = wayHit[1];

  // invalid way first, way 0 before way 1, then the LRU victim
  always_comb begin
    if (!validQ[0]) begin
      victim = 1'b0;
    end else if (!validQ[1]) begin
      victim = 1'b1;
    end else begin
      victim = lruArr[reqQ.fields.index];
    end
  end

  assign compareHit  = (state == Compare) && hit;
  assign compareMiss = (state == Compare) && !hit;
  assign inGetData   = (state == GetData);

  // new request taken from idle or behind a hit
  assign accept = req_i.valid && ((state == Idle) || compareHit);

  always_comb begin
    stateNext = state;
    case (state)
      Idle: begin
        if (req_i.valid) begin
          stateNext = Compare;
        end
      end
      Compare: begin
        if (!hit) begin
          stateNext = Miss;
        end else if (!req_i.valid) begin
          stateNext = Idle;
        end
      end
      Miss: begin
        if (lineReady_i) begin
          stateNext = GetData;
        end
      end
      GetData: begin
        stateNext = Idle;
      end
      default: begin
        stateNext = Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= Idle;
      validQ   <= '0;
      validArr <= '0;
      lruArr   <= '0;
      victimQ  <= 1'b0;
      dataOkQ  <= 1'b0;
    end else begin
      state <= stateNext;
      if (accept) begin
        for (int w = 0; w < NumWays; w++) begin
          validQ[w] <= validArr[w][req_i.addr.fields.index];
        end
      end
      if (compareMiss) begin
        victimQ <= victim;
      end
      // the way just used is kept, the other becomes next victim
      if (compareHit) begin
        lruArr[reqQ.fields.index] <= ~hitWay;
      end
      if (inGetData) begin
        validArr[victimQ][reqQ.fields.index] <= 1'b1;
        lruArr[reqQ.fields.index]            <= ~victimQ;
      end
      dataOkQ <= compareHit || inGetData;
    end
  end

  // request and tag snapshot taken at accept
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i.addr;
      for (int w = 0; w < NumWays; w++) begin
        tagQ[w] <= tagArr[w][req_i.addr.fields.index];
      end
    end
    if (inGetData) begin
      tagArr[victimQ][reqQ.fields.index] <= reqQ.fields.tag;
    end
  end

  // hit word from the array, miss word from the refill line
  always_ff @(posedge clk) begin
    if (compareHit) begin
      dataQ <= selectWord(rdLines_i[hitWay], reqQ.fields.offset);
    end else if (inGetData) begin
      dataQ <= selectWord(refillLine_i, reqQ.fields.offset);
    end
  end

  // line-aligned bus address
  always_comb begin
    lineAddr               = reqQ;
    lineAddr.fields.offset = '0;
  end

  assign addrOk_o      = accept;
  assign resp_o        = '{dataOk: dataOkQ, data: dataQ};
  assign memRdReq_o    = (state == Miss);
  assign memAddr_o     = lineAddr.raw;
  assign refillClear_o = compareMiss;
  assign rdEn_o        = accept;
  assign rdIndex_o     = req_i.addr.fields.index;
  assign wrEn_o        = inGetData;
  assign wrWay_o       = victimQ;
  assign wrIndex_o     = reqQ.fields.index;

endmodule

//--- verilog/cacheTop.sv
module cacheTop (
  input  logic                clk,
  input  logic                rst_n,
  input  cachePkg::cacheReqT  req_i,
  output logic                addrOk_o,
  output cachePkg::cacheRespT resp_o,
  output logic                memRdReq_o,
  output logic [31:0]         memAddr_o,
  input  busPkg::busBeatT     mem_i
);
  import cachePkg::*;

  logic                            rdEn;
  logic [IndexBits-1:0]            rdIndex;
  logic [NumWays-1:0][LineBits-1:0] rdLines;
  logic                            wrEn;
  logic                            wrWay;
  logic [IndexBits-1:0]            wrIndex;
  logic                            refillClear;
  logic                            lineReady;
  logic [LineBits-1:0]             refillLine;

  cacheCtrl uCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .addrOk_o     (addrOk_o),
    .resp_o       (resp_o),
    .memRdReq_o   (memRdReq_o),
    .memAddr_o    (memAddr_o),
    .rdEn_o       (rdEn),
    .rdIndex_o    (rdIndex),
    .rdLines_i    (rdLines),
    .wrEn_o       (wrEn),
    .wrWay_o      (wrWay),
    .wrIndex_o    (wrIndex),
    .refillClear_o(refillClear),
    .lineReady_i  (lineReady),
    .refillLine_i (refillLine)
  );

  // refill line is written straight into the chosen way
  dataArray uData (
    .clk      (clk),
    .rdEn_i   (rdEn),
    .rdIndex_i(rdIndex),
    .rdLines_o(rdLines),
    .wrEn_i   (wrEn),
    .wrWay_i  (wrWay),
    .wrIndex_i(wrIndex),
    .wrLine_i (refillLine)
  );

  refillBuffer uRefill (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (refillClear),
    .mem_i      (mem_i),
    .lineReady_o(lineReady),
    .line_o     (refillLine)
  );

endmodule

//--- test/cacheAsserts.sv
module cacheAsserts (
  input logic                clk,
  input logic                rst_n,
  input logic                addrOk_i,
  input cachePkg::cacheRespT resp_i,
  input logic                memRdReq_i,
  input logic                lineReady_i
);

  // lineReady follows the beat with last by one cycle
  refillHeldA: assert property (
    @(posedge clk) disable iff (!rst_n)
      memRdReq_i && !lineReady_i |=> memRdReq_i
  ) else $error("memRdReq_o dropped before the last beat arrived");

  // a second dataOk cycle only behind a request taken during compare
  dataOkPulseA: assert property (
    @(posedge clk) disable iff (!rst_n)
      resp_i.dataOk && !$past(addrOk_i) |=> !resp_i.dataOk
  ) else $error("dataOk stayed high with no second request accepted");

  // two cycles after accept, either the hit word or the refill request
  acceptAnsweredA: assert property (
    @(posedge clk) disable iff (!rst_n)
      $past(addrOk_i, 2) |-> resp_i.dataOk || memRdReq_i
  ) else $error("accepted request got neither dataOk nor memRdReq_o");

endmodule

bind cacheCtrl cacheAsserts uAsserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .addrOk_i    (addrOk_o),
  .resp_i      (resp_o),
  .memRdReq_i  (memRdReq_o),
  .lineReady_i (lineReady_i)
);

//--- test/cacheTb.sv
module cacheTb;
  import cachePkg::*;
  import busPkg::*;

  localparam int NumReqs       = 400;
  localparam int TimeoutCycles = NumReqs * 40;
  localparam int Seed          = 2;

  typedef struct packed {
    logic [31:0] addr;
    logic        hit;
    logic [31:0] cycle;
  } expectT;

  logic        clk;
  logic        rst_n;
  cacheReqT    req;
  logic        addrOk;
  cacheRespT   resp;
  logic        memRdReq;
  logic [31:0] memAddr;
  busBeatT     memBeat;

  int          reqSeed;
  int          busSeed;
  logic [31:0] cycles;
  int          responses;
  int          refills;
  int          missCount;
  logic        reqSeen;
  expectT      expQ[$];
  logic [31:0] missQ[$];

  // reference copy of tags, valid bits and LRU bits
  logic [TagBits-1:0] mTag   [NumWays][NumSets];
  logic               mValid [NumWays][NumSets];
  logic               mLru   [NumSets];

  cacheTop UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req),
    .addrOk_o  (addrOk),
    .resp_o    (resp),
    .memRdReq_o(memRdReq),
    .memAddr_o (memAddr),
    .mem_i     (memBeat)
  );

  always #50 clk = ~clk;

  // memory contents as a mix of the byte address
  function automatic logic [63:0] memWord(input logic [31:0] addr);
    return {addr ^ 32'hC3A5_5A3C, addr * 32'h9E37_79B1 + 32'h1234_5678};
  endfunction

  task automatic abortRun();
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at cycle %0d", cycles);
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  // invalid way 0, then way 1, then the LRU way
  task automatic updateModel(input cacheAddrT a, output logic hit);
    logic [IndexBits-1:0] idx;
    logic                 way;
    idx = a.fields.index;
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (mValid[w][idx] && mTag[w][idx] == a.fields.tag) begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
    if (!hit) begin
      way = !mValid[0][idx] ? 1'b0 : (!mValid[1][idx] ? 1'b1 : mLru[idx]);
      mValid[way][idx] = 1'b1;
      mTag[way][idx]   = a.fields.tag;
      missCount++;
      missQ.push_back({a.raw[31:5], 5'b00000});
    end
    mLru[idx] = ~way;
  endtask

  initial begin : requester
    cacheAddrT   addr;
    logic [31:0] r;
    logic        hit;
    logic        prevHit;
    logic        noGap;
    logic [31:0] prevCycle;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    memBeat   = '0;
    cycles    = '0;
    responses = 0;
    refills   = 0;
    missCount = 0;
    reqSeen   = 1'b0;
    reqSeed   = Seed;
    for (int s = 0; s < NumSets; s++) begin
      mValid[0][s] = 1'b0;
      mValid[1][s] = 1'b0;
      mLru[s]      = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n     = 1'b1;
    prevHit   = 1'b0;
    prevCycle = '0;
    for (int n = 0; n < NumReqs; n++) begin
      // four tags over four sets keeps sets full and evicting
      r = $random(reqSeed);
      addr.raw          = r;
      addr.fields.tag   = 21'h15A00 + 21'(r[31:30]);
      addr.fields.index = 6'(r[9:8]);
      noGap             = (r[13:12] != 2'b00);
      @(negedge clk);
      if (!noGap) begin
        req.valid = 1'b0;
        @(negedge clk);
      end
      req.valid = 1'b1;
      req.addr  = addr;
      @(posedge clk);
      while (!addrOk) @(posedge clk);
      updateModel(addr, hit);
      // a request right behind a hit is taken in its compare cycle
      if (prevHit && noGap) begin
        checkValue("addrOk_o cycle", 64'(cycles), 64'(prevCycle + 1));
      end
      expQ.push_back('{addr: addr.raw, hit: hit, cycle: cycles});
      prevHit   = hit;
      prevCycle = cycles;
    end
    @(negedge clk);
    req.valid = 1'b0;
    while (responses < NumReqs) @(posedge clk);
    checkValue("refill count", 64'(refills), 64'(missCount));
    $display("RESULT: PASS");
    $finish;
  end

  // bus side, random start delay and gaps between beats
  initial begin : responder
    logic [31:0] lineAddr;
    logic        served;
    busSeed = Seed;
    served  = 1'b0;
    forever begin
      @(negedge clk);
      if (!memRdReq) begin
        served = 1'b0;
      end else if (!served) begin
        lineAddr = memAddr;
        repeat ({$random(busSeed)} % 6) @(negedge clk);
        for (int k = 0; k < BeatsPerLine; k++) begin
          repeat ({$random(busSeed)} % 3) @(negedge clk);
          memBeat.valid = 1'b1;
          memBeat.last  = (k == BeatsPerLine - 1);
          memBeat.data  = memWord(lineAddr + 32'(8 * k));
          @(negedge clk);
          memBeat = '0;
        end
        served = 1'b1;
      end
    end
  end

  always @(posedge clk) begin : monitor
    expectT e;
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout after %0d cycles with %0d of %0d responses", cycles, responses, NumReqs);
      abortRun();
    end
    if (rst_n) begin
      if (memRdReq) begin
        checkValue("addrOk_o during refill", 64'(addrOk), 64'd0);
        checkValue("resp_o.dataOk during refill", 64'(resp.dataOk), 64'd0);
        if (!reqSeen) begin
          if (missQ.size() == 0) begin
            $display("refill requested for an address the model holds");
            abortRun();
          end
          checkValue("memAddr_o", 64'(memAddr), 64'(missQ.pop_front()));
          refills++;
        end
      end
      reqSeen = memRdReq;
      if (resp.dataOk) begin
        if (expQ.size() == 0) begin
          $display("dataOk seen with no request outstanding");
          abortRun();
        end
        e = expQ.pop_front();
        checkValue("resp_o.data", resp.data, memWord({e.addr[31:3], 3'b000}));
        if (e.hit) begin
          checkValue("hit dataOk cycle", 64'(cycles), 64'(e.cycle + 2));
        end
        responses++;
      end
    end
  end

endmodule

//--- filelist.f
verilog/cachePkg.sv
verilog/busPkg.sv
verilog/dataArray.sv
verilog/refillBuffer.sv
verilog/cacheCtrl.sv
verilog/cacheTop.sv
test/cacheAsserts.sv
test/cacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    --top-module cacheTb -f filelist.f -o cacheSim &&
  ./obj_dir/cacheSim &&
  echo "simulation ended cleanly" ||
  { echo "simulation reported a failure"; exit 1; }
